// File: vlog.f
hw/qspi_pkg.sv
hw/qspi_shift_engine.sv
hw/qspi_rx_buffer.sv
hw/qspi_apb_regs.sv
hw/qspi_host_top.sv
sim/qspi_host_chk.sv
sim/qspi_host_tb.sv

// File: sim/qspi_host_tb.sv
`timescale 1ns/100ps
`default_nettype none

module qspi_host_tb;
	import qspi_pkg::*;

	localparam int CLK_PERIOD = 20;
	// Outputs read a quarter period after the falling edge
	localparam int SAMPLE_NS = CLK_PERIOD / 4;
	localparam int N_ROWS = 32;
	// Normal byte at the largest divider used, plus handshake overhead
	localparam int BYTE_CYCLES = 16 * 4 + 6;
	localparam int WATCHDOG_NS = N_ROWS * BYTE_CYCLES * 4 * CLK_PERIOD;

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_POLL} op_t;

	// One stimulus row
	typedef struct packed {
		op_t       op;
		reg_addr_t addr;
		word_t     wdata;
		word_t     exp;
		logic      exp_err;
	} row_t;

	logic apb;
	logic rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic qspi_sck;
	logic qspi_cs_n;
	nibble_t qspi_dq_out;
	nibble_t qspi_dq_tris;
	nibble_t qspi_dq_in;

	row_t rows [N_ROWS];
	int row_cnt;
	integer seed;
	// First byte served by the flash in quad mode
	byte_t quad_base;
	// Byte the flash is serving now
	byte_t flash_byte;
	int nib_idx;
	logic sck_prev;

	qspi_host_top #(
		.BUF_WORDS(8),
		.CLKDIV_RESET(4)
	) dut (
		.apb(apb), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.qspi_sck(qspi_sck), .qspi_cs_n(qspi_cs_n), .qspi_dq_out(qspi_dq_out),
		.qspi_dq_tris(qspi_dq_tris), .qspi_dq_in(qspi_dq_in)
	);

	always #(CLK_PERIOD / 2) apb = ~apb;

	//////////////////////////////////////////////////////////////////////
	// Flash model

	// Byte k of the quad stream
	function automatic byte_t model_byte(input int k);
		return quad_base + byte_t'(k);
	endfunction

	// Burst word w, little endian
	function automatic word_t quad_word(input int w);
		word_t v;
		v = '0;
		for (int k = 0; k < 4; k++)
			v[k*8 +: 8] = model_byte(4 * w + k);
		return v;
	endfunction

	// Quad lines advance a nibble per SCK fall, high nibble first
	always @(negedge apb) begin
		if (qspi_dq_tris == 4'b1111) begin
			if (sck_prev && !qspi_sck)
				nib_idx = nib_idx + 1;
			flash_byte = model_byte(nib_idx / 2);
			qspi_dq_in = (nib_idx % 2) ? flash_byte[3:0] : flash_byte[7:4];
		end else begin
			// MOSI looped to MISO
			qspi_dq_in = {2'b00, qspi_dq_out[0], 1'b0};
		end
		sck_prev = qspi_sck;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks and bus tasks

	task automatic check(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("error: time %0t signal %s got 0x%08h expected 0x%08h",
				$time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// One APB transfer, waits out stalled reads
	task automatic apb_xfer(input logic wr, input reg_addr_t addr, input word_t wdata,
		output word_t rdata, output logic err);
		@(negedge apb);
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		apb_req.pwrite = wr;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		@(negedge apb);
		apb_req.penable = 1'b1;
		#(SAMPLE_NS);
		while (!apb_rsp.pready) begin
			@(negedge apb);
			#(SAMPLE_NS);
		end
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		// Access ends on the next rising edge
		@(negedge apb);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
	endtask

	task automatic add_row(input op_t op, input reg_addr_t addr, input word_t wdata,
		input word_t exp, input logic exp_err);
		rows[row_cnt] = '{op: op, addr: addr, wdata: wdata, exp: exp, exp_err: exp_err};
		row_cnt = row_cnt + 1;
	endtask

	task automatic run_row(input row_t r);
		word_t rdata;
		logic err;
		case (r.op)
			OP_WRITE: begin
				apb_xfer(1'b1, r.addr, r.wdata, rdata, err);
				check($sformatf("pslverr wr %03h", r.addr), word_t'(err), word_t'(r.exp_err));
			end
			OP_READ: begin
				apb_xfer(1'b0, r.addr, '0, rdata, err);
				check($sformatf("pslverr rd %03h", r.addr), word_t'(err), word_t'(r.exp_err));
				if (!r.exp_err)
					check($sformatf("prdata %03h", r.addr), rdata, r.exp);
				// CS register mirrors the pin
				if (r.addr == REG_CS_N)
					check("qspi_cs_n", word_t'(qspi_cs_n), word_t'(r.exp[0]));
			end
			default: begin
				// Status poll, watchdog bounds it
				do
					apb_xfer(1'b0, r.addr, '0, rdata, err);
				while (!err && (rdata != r.exp));
				check("pslverr poll", word_t'(err), word_t'(r.exp_err));
			end
		endcase
	endtask

	task automatic build_table();
		// Reset values
		add_row(OP_READ, REG_CLK_DIV, '0, 32'd4, 1'b0);
		add_row(OP_READ, REG_CS_N, '0, 32'd1, 1'b0);
		add_row(OP_READ, REG_STATUS, '0, 32'd0, 1'b0);
		add_row(OP_READ, REG_STATUS_2, '0, 32'd0, 1'b0);
		add_row(OP_READ, REG_QUAD_CAP, '0, 32'd1, 1'b0);
		// CS and divider
		add_row(OP_WRITE, REG_CS_N, 32'd0, '0, 1'b0);
		add_row(OP_READ, REG_CS_N, '0, 32'd0, 1'b0);
		add_row(OP_WRITE, REG_CLK_DIV, 32'd2, '0, 1'b0);
		add_row(OP_READ, REG_CLK_DIV, '0, 32'd2, 1'b0);
		// Single byte, second write hits a busy engine
		add_row(OP_WRITE, REG_DATA, 32'ha5, '0, 1'b0);
		add_row(OP_WRITE, REG_DATA, 32'h3c, '0, 1'b1);
		add_row(OP_POLL, REG_STATUS, '0, 32'd0, 1'b0);
		add_row(OP_READ, REG_DATA, '0, 32'ha5, 1'b0);
		// Quad burst, reads go out ahead of the data
		add_row(OP_WRITE, REG_QBURST_RDLEN, 32'd12, '0, 1'b0);
		for (int w = 0; w < 3; w++)
			add_row(OP_READ, REG_BURST_RXBUF + reg_addr_t'(4 * w), '0, quad_word(w), 1'b0);
		add_row(OP_POLL, REG_STATUS, '0, 32'd0, 1'b0);
		// Normal burst clamped to 8 words of zeros
		add_row(OP_WRITE, REG_BURST_RDLEN, 32'd300, '0, 1'b0);
		add_row(OP_POLL, REG_STATUS_2, '0, 32'd0, 1'b0);
		for (int w = 0; w < 8; w++)
			add_row(OP_READ, REG_BURST_RXBUF + reg_addr_t'(4 * w), '0, 32'd0, 1'b0);
		// Decode errors
		add_row(OP_READ, 9'h010, '0, '0, 1'b1);
		add_row(OP_WRITE, 9'h010, 32'd1, '0, 1'b1);
		add_row(OP_WRITE, REG_STATUS, 32'd1, '0, 1'b1);
		add_row(OP_READ, REG_BURST_RXBUF + 9'h020, '0, '0, 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog

	initial begin
		apb = 1'b0;
		rst_n = 1'b0;
		apb_req = '0;
		qspi_dq_in = '0;
		sck_prev = 1'b0;
		nib_idx = 0;
		row_cnt = 0;
		seed = 32'h5740;
		quad_base = byte_t'($random(seed));
		build_table();
		repeat (5) @(negedge apb);
		rst_n = 1'b1;
		for (int i = 0; i < row_cnt; i++)
			run_row(rows[i]);
		$display("TESTS PASSED");
		$finish;
	end

	// Bound engine checker
	always @(dut.u_engine.u_chk.fail_cnt) begin
		if (dut.u_engine.u_chk.fail_cnt != 0) begin
			$display("error: time %0t a handshake or pin assertion failed", $time);
			$display("TESTS FAILED");
			$fatal(1, "assertion failure");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("error: time %0t the run hung and the watchdog expired", $time);
		$display("TESTS FAILED");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire

// File: sim/qspi_host_chk.sv
`timescale 1ns/100ps
`default_nettype none

module qspi_host_chk (
	input logic                 apb,
	input logic                 rst_n,
	input logic                 shift_req,
	input qspi_pkg::shift_cmd_t shift_cmd,
	input logic                 shift_ack,
	input logic                 qspi_sck,
	input logic [1:0]           state
);
	// Encoding of ST_IDLE in the engine FSM
	localparam logic [1:0] IDLE_CODE = 2'd0;

	// Failed assertions so far
	int fail_cnt = 0;

	//////////////////////////////////////////////////////////////////////
	// Four-phase handshake

	// Ack only answers a pending request
	ack_needs_req: assert property (@(posedge apb) disable iff (!rst_n)
		$rose(shift_ack) |-> shift_req)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("shift_ack rose while shift_req was low");
		end

	// Command held for the whole request
	cmd_stable: assert property (@(posedge apb) disable iff (!rst_n)
		(shift_req && $past(shift_req)) |-> $stable(shift_cmd))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("shift_cmd changed while shift_req was high");
		end

	//////////////////////////////////////////////////////////////////////
	// Pins

	// SCK parked low between bytes
	sck_idle_low: assert property (@(posedge apb) disable iff (!rst_n)
		(state == IDLE_CODE) |-> !qspi_sck)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("qspi_sck high while the engine is idle");
		end

endmodule

bind qspi_shift_engine qspi_host_chk u_chk (
	.apb(apb), .rst_n(rst_n), .shift_req(shift_req), .shift_cmd(shift_cmd),
	.shift_ack(shift_ack), .qspi_sck(qspi_sck), .state(state)
);

`default_nettype wire

// File: hw/qspi_host_top.sv
`timescale 1ns/100ps
`default_nettype none

module qspi_host_top #(
	parameter int BUF_WORDS    = 64,
	parameter int CLKDIV_RESET = 4
) (
	input  logic               apb,
	input  logic               rst_n,
	input  qspi_pkg::apb_req_t apb_req,
	output qspi_pkg::apb_rsp_t apb_rsp,
	output logic               qspi_sck,
	output logic               qspi_cs_n,
	output qspi_pkg::nibble_t  qspi_dq_out,
	output qspi_pkg::nibble_t  qspi_dq_tris,
	input  qspi_pkg::nibble_t  qspi_dq_in
);
	import qspi_pkg::*;

	localparam int IDX_W = $clog2(BUF_WORDS);

	//////////////////////////////////////////////////////////////////////
	// Internal links

	// Register block to engine
	clkdiv_t clkdiv;
	logic shift_req;
	logic shift_ack;
	shift_cmd_t shift_cmd;
	byte_t rx_byte;

	// Register block to buffer
	logic burst_start;
	logic rx_push;
	logic [IDX_W-1:0] rd_index;
	word_t rd_word;
	logic [IDX_W:0] wr_ptr;
	logic wr_now;

	qspi_apb_regs #(
		.BUF_WORDS(BUF_WORDS),
		.CLKDIV_RESET(CLKDIV_RESET)
	) u_regs (
		.apb(apb), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
		.clkdiv(clkdiv), .qspi_cs_n(qspi_cs_n),
		.shift_req(shift_req), .shift_cmd(shift_cmd), .shift_ack(shift_ack),
		.rx_byte(rx_byte), .burst_start(burst_start), .rx_push(rx_push),
		.rd_index(rd_index), .rd_word(rd_word), .wr_ptr(wr_ptr), .wr_now(wr_now)
	);

	qspi_shift_engine u_engine (
		.apb(apb), .rst_n(rst_n), .clkdiv(clkdiv),
		.shift_req(shift_req), .shift_cmd(shift_cmd), .shift_ack(shift_ack),
		.rx_byte(rx_byte), .qspi_sck(qspi_sck), .qspi_dq_out(qspi_dq_out),
		.qspi_dq_in(qspi_dq_in), .qspi_dq_tris(qspi_dq_tris)
	);

	qspi_rx_buffer #(
		.BUF_WORDS(BUF_WORDS)
	) u_rxbuf (
		.apb(apb), .rst_n(rst_n), .burst_start(burst_start), .rx_push(rx_push),
		.rx_byte(rx_byte), .rd_index(rd_index), .rd_word(rd_word),
		.wr_ptr(wr_ptr), .wr_now(wr_now)
	);

endmodule

`default_nettype wire

// File: hw/qspi_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module qspi_apb_regs #(
	parameter int BUF_WORDS    = 64,
	parameter int CLKDIV_RESET = 4
) (
	input  logic                         apb,
	input  logic                         rst_n,
	input  qspi_pkg::apb_req_t           apb_req,
	output qspi_pkg::apb_rsp_t           apb_rsp,
	output qspi_pkg::clkdiv_t            clkdiv,
	output logic                         qspi_cs_n,
	output logic                         shift_req,
	output qspi_pkg::shift_cmd_t         shift_cmd,
	input  logic                         shift_ack,
	input  qspi_pkg::byte_t              rx_byte,
	output logic                         burst_start,
	output logic                         rx_push,
	output logic [$clog2(BUF_WORDS)-1:0] rd_index,
	input  qspi_pkg::word_t              rd_word,
	input  logic [$clog2(BUF_WORDS):0]   wr_ptr,
	input  logic                         wr_now
);
	import qspi_pkg::*;

	localparam int IDX_W = $clog2(BUF_WORDS);
	// Words reachable through the window
	localparam logic [6:0] WIN_WORDS = 7'(BUF_WORDS);
	// Largest burst that fits the buffer
	localparam word_t BURST_MAX = word_t'(BUF_WORDS * 4);

	typedef enum logic [1:0] {
		BURST_IDLE,
		BURST_NORMAL,
		BURST_QUAD
	} burst_t;

	burst_t burst_state;
	burst_len_t burst_left;
	byte_t rx_last;
	word_t clamped_len;
	logic access;
	logic burst_active;
	logic busy;
	logic ack_seen;
	logic in_win;
	logic win_ok;
	logic stall;
	logic [5:0] win_word;
	logic start_single;
	logic wr_ok;

	//////////////////////////////////////////////////////////////////////
	// Decode helpers

	assign access = apb_req.psel && apb_req.penable;
	assign burst_active = (burst_state != BURST_IDLE);
	// Busy until the handshake is fully closed
	assign busy = burst_active || shift_req || shift_ack;
	assign ack_seen = shift_req && shift_ack;
	assign rx_push = ack_seen && burst_active;

	assign in_win = (apb_req.paddr >= REG_BURST_RXBUF);
	assign win_word = apb_req.paddr[7:2];
	assign win_ok = in_win && (apb_req.paddr[1:0] == 2'b00) && ({1'b0, win_word} < WIN_WORDS);
	assign rd_index = win_word[IDX_W-1:0];

	// Read ahead of capture waits for the word to land
	assign stall = access && !apb_req.pwrite && win_ok && burst_active &&
		!({1'b0, rd_index} < wr_ptr) && !(wr_now && ({1'b0, rd_index} == wr_ptr));

	assign clamped_len = (apb_req.pwdata > BURST_MAX) ? BURST_MAX : apb_req.pwdata;

	//////////////////////////////////////////////////////////////////////
	// APB response

	always_comb begin
		apb_rsp.prdata = '0;
		apb_rsp.pready = !stall;
		apb_rsp.pslverr = 1'b0;
		start_single = 1'b0;
		burst_start = 1'b0;
		if (access && !stall) begin
			if (apb_req.pwrite) begin
				case (apb_req.paddr)
					REG_CLK_DIV, REG_CS_N: ;
					// Byte exchange refused while engine busy
					REG_DATA: begin
						if (busy)
							apb_rsp.pslverr = 1'b1;
						else
							start_single = 1'b1;
					end
					REG_BURST_RDLEN, REG_QBURST_RDLEN: begin
						if (busy)
							apb_rsp.pslverr = 1'b1;
						else
							burst_start = 1'b1;
					end
					// Read-only, window or unmapped
					default: apb_rsp.pslverr = 1'b1;
				endcase
			end else if (in_win) begin
				if (win_ok)
					apb_rsp.prdata = rd_word;
				else
					apb_rsp.pslverr = 1'b1;
			end else begin
				case (apb_req.paddr)
					REG_CLK_DIV: apb_rsp.prdata = {16'h0000, clkdiv};
					REG_DATA: apb_rsp.prdata = {24'h000000, rx_last};
					REG_CS_N: apb_rsp.prdata = {31'h0, qspi_cs_n};
					REG_STATUS, REG_STATUS_2: apb_rsp.prdata = {31'h0, busy};
					REG_QUAD_CAP: apb_rsp.prdata = 32'h1;
					default: apb_rsp.pslverr = 1'b1;
				endcase
			end
		end
		wr_ok = access && apb_req.pwrite && !apb_rsp.pslverr;
	end

	//////////////////////////////////////////////////////////////////////
	// Registers, handshake and burst sequencing

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			clkdiv <= clkdiv_t'(CLKDIV_RESET);
			qspi_cs_n <= 1'b1;
			shift_req <= 1'b0;
			shift_cmd <= '0;
			burst_state <= BURST_IDLE;
			burst_left <= '0;
			rx_last <= '0;
		end else begin
			if (wr_ok) begin
				case (apb_req.paddr)
					REG_CLK_DIV: clkdiv <= apb_req.pwdata[15:0];
					REG_CS_N: qspi_cs_n <= apb_req.pwdata[0];
					default: ;
				endcase
			end

			// Byte done, drop request and count it
			if (ack_seen) begin
				shift_req <= 1'b0;
				rx_last <= rx_byte;
				if (burst_active) begin
					burst_left <= burst_left - 1'b1;
					if (burst_left == burst_len_t'(1))
						burst_state <= BURST_IDLE;
				end
			end else if (start_single) begin
				shift_req <= 1'b1;
				shift_cmd <= '{tx_data: apb_req.pwdata[7:0], quad: 1'b0};
			end else if (burst_active && !shift_req && !shift_ack) begin
				// Next burst byte, dummy 0x00 out
				shift_req <= 1'b1;
				shift_cmd <= '{tx_data: 8'h00, quad: (burst_state == BURST_QUAD)};
			end

			// Empty burst only clears the buffer
			if (burst_start && (clamped_len != '0)) begin
				burst_left <= burst_len_t'(clamped_len);
				if (apb_req.paddr == REG_QBURST_RDLEN)
					burst_state <= BURST_QUAD;
				else
					burst_state <= BURST_NORMAL;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/qspi_rx_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module qspi_rx_buffer #(
	parameter int BUF_WORDS = 64
) (
	input  logic                         apb,
	input  logic                         rst_n,
	input  logic                         burst_start,
	input  logic                         rx_push,
	input  qspi_pkg::byte_t              rx_byte,
	input  logic [$clog2(BUF_WORDS)-1:0] rd_index,
	output qspi_pkg::word_t              rd_word,
	output logic [$clog2(BUF_WORDS):0]   wr_ptr,
	output logic                         wr_now
);
	import qspi_pkg::*;

	localparam int IDX_W = $clog2(BUF_WORDS);

	word_t mem [BUF_WORDS];

	// Bytes of the word in progress
	word_t lane_word;
	word_t wr_word;
	logic [1:0] lane;

	//////////////////////////////////////////////////////////////////////
	// Word assembly, little endian

	// Fourth byte completes the word
	assign wr_now = rx_push && (lane == 2'd3);
	assign wr_word = {rx_byte, lane_word[23:0]};

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			lane <= '0;
			wr_ptr <= '0;
		end else if (burst_start) begin
			lane <= '0;
			wr_ptr <= '0;
		end else if (rx_push) begin
			lane <= lane + 2'd1;
			if (wr_now)
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge apb) begin
		if (rx_push)
			lane_word[{lane, 3'b000} +: 8] <= rx_byte;
		if (wr_now)
			mem[wr_ptr[IDX_W-1:0]] <= wr_word;
	end

	//////////////////////////////////////////////////////////////////////
	// Read port

	// Forward the word landing this cycle
	always_comb begin
		if (wr_now && (rd_index == wr_ptr[IDX_W-1:0]))
			rd_word = wr_word;
		else
			rd_word = mem[rd_index];
	end

endmodule

`default_nettype wire

// File: hw/qspi_shift_engine.sv
`timescale 1ns/100ps
`default_nettype none

module qspi_shift_engine (
	input  logic                 apb,
	input  logic                 rst_n,
	input  qspi_pkg::clkdiv_t    clkdiv,
	input  logic                 shift_req,
	input  qspi_pkg::shift_cmd_t shift_cmd,
	output logic                 shift_ack,
	output qspi_pkg::byte_t      rx_byte,
	output logic                 qspi_sck,
	output qspi_pkg::nibble_t    qspi_dq_out,
	input  qspi_pkg::nibble_t    qspi_dq_in,
	output qspi_pkg::nibble_t    qspi_dq_tris
);
	import qspi_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_ACK,
		ST_WAIT_DROP
	} state_t;

	state_t state;

	// Half period timer
	clkdiv_t half_cnt;
	logic half_done;

	// SCK edge counter within one byte
	logic [3:0] edge_cnt;
	logic [3:0] last_edge;
	logic sample_edge;

	// Current byte is quad
	logic quad;
	byte_t tx_sr;
	byte_t rx_sr;

	//////////////////////////////////////////////////////////////////////
	// Edge timing

	// Zero divider behaves like one
	assign half_done = clkdiv_t'(half_cnt + 16'd1) >= clkdiv;

	// 16 edges for one line, 4 for four lines
	assign last_edge = quad ? 4'd3 : 4'd15;

	// Rising SCK edge about to happen
	assign sample_edge = (state == ST_SHIFT) && half_done && !qspi_sck;

	//////////////////////////////////////////////////////////////////////
	// Pin drive

	// MSB on dq0 in normal mode
	assign qspi_dq_out = quad ? nibble_t'(4'b0000) : {3'b000, tx_sr[7]};
	// All lines released for quad reads
	assign qspi_dq_tris = quad ? nibble_t'(4'b1111) : nibble_t'(4'b1110);

	//////////////////////////////////////////////////////////////////////
	// Handshake and SCK FSM

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			qspi_sck <= 1'b0;
			shift_ack <= 1'b0;
			quad <= 1'b0;
			half_cnt <= '0;
			edge_cnt <= '0;
			tx_sr <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// Latch command, first bit goes out now
					if (shift_req) begin
						tx_sr <= shift_cmd.tx_data;
						quad <= shift_cmd.quad;
						half_cnt <= '0;
						edge_cnt <= '0;
						state <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					if (half_done) begin
						half_cnt <= '0;
						qspi_sck <= !qspi_sck;
						edge_cnt <= edge_cnt + 4'd1;
						// Falling edge moves next bit out
						if (qspi_sck)
							tx_sr <= {tx_sr[6:0], 1'b0};
						// Last edge is falling, SCK ends low
						if (edge_cnt == last_edge)
							state <= ST_ACK;
					end else begin
						half_cnt <= half_cnt + 16'd1;
					end
				end
				ST_ACK: begin
					shift_ack <= 1'b1;
					state <= ST_WAIT_DROP;
				end
				ST_WAIT_DROP: begin
					// Requester done, close the handshake
					if (!shift_req) begin
						shift_ack <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Receive shifter, MISO on dq1 or a full nibble
	always_ff @(posedge apb) begin
		if (sample_edge)
			rx_sr <= quad ? {rx_sr[3:0], qspi_dq_in} : {rx_sr[6:0], qspi_dq_in[1]};
		if (state == ST_ACK)
			rx_byte <= rx_sr;
	end

endmodule

`default_nettype wire

// File: hw/qspi_pkg.sv
`default_nettype none

package qspi_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths with a meaning

	// One serial byte
	typedef logic [7:0] byte_t;
	// One APB data word
	typedef logic [31:0] word_t;
	// Register offset within the completer
	typedef logic [8:0] reg_addr_t;
	// SCK half period in APB clocks
	typedef logic [15:0] clkdiv_t;
	// Burst byte count, up to 256
	typedef logic [8:0] burst_len_t;
	// The four QSPI data lines
	typedef logic [3:0] nibble_t;

	//////////////////////////////////////////////////////////////////////
	// Register map, 0x20 spacing

	localparam reg_addr_t REG_CLK_DIV      = 9'h000;
	localparam reg_addr_t REG_DATA         = 9'h020;
	localparam reg_addr_t REG_CS_N         = 9'h040;
	localparam reg_addr_t REG_STATUS       = 9'h060;
	localparam reg_addr_t REG_STATUS_2     = 9'h080;
	localparam reg_addr_t REG_BURST_RDLEN  = 9'h0a0;
	localparam reg_addr_t REG_QUAD_CAP     = 9'h0c0;
	localparam reg_addr_t REG_QBURST_RDLEN = 9'h0e0;
	// Receive buffer window, always last in the map
	localparam reg_addr_t REG_BURST_RXBUF  = 9'h100;

	//////////////////////////////////////////////////////////////////////
	// Bundled signals

	// Requester to completer
	typedef struct packed {
		reg_addr_t paddr;
		word_t     pwdata;
		logic      pwrite;
		logic      psel;
		logic      penable;
	} apb_req_t;

	// Completer to requester
	typedef struct packed {
		word_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	// One byte for the shift engine
	typedef struct packed {
		byte_t tx_data;
		logic  quad;
	} shift_cmd_t;

endpackage

`default_nettype wire
